/* src/sb_pkg.sv */
package sb_pkg;

    ////////////////////
    // packet geometry
    ////////////////////
    localparam int SB_PACKET_W   = 64;  // one sideband packet
    localparam int SB_DATA_W     = 16;  // payload word
    localparam int SB_MSG_NO_W   = 4;
    localparam int SB_MSG_INFO_W = 3;
    localparam int SB_CNT_W      = 6;   // counts 0..63 bits
    localparam int SB_OPCODE_W   = 5;

    // field positions, lsb of each field
    localparam int SB_OPCODE_LSB   = 0;
    localparam int SB_MSG_NO_LSB   = 5;
    localparam int SB_MSG_INFO_LSB = 9;
    localparam int SB_DATA_LSB     = 12;  // also the header width
    localparam int SB_DP_BIT       = 28;  // data parity
    localparam int SB_CP_BIT       = 29;  // control parity, reserved above

    ////////////////////
    // encodings
    ////////////////////
    typedef enum logic [SB_OPCODE_W-1:0] {
        SB_OP_MSG_NODATA = 5'b10010,  // message only
        SB_OP_MSG_DATA16 = 5'b11011   // message + 16b data
    } sb_opcode_e;

    typedef enum logic {
        SER_IDLE  = 1'b0,
        SER_SHIFT = 1'b1
    } sb_ser_state_e;

    ////////////////////
    // parity rules
    ////////////////////
    // xor of the 16 data bits
    function automatic logic sb_data_parity(input logic [SB_PACKET_W-1:0] pkt);
        return ^pkt[SB_DATA_LSB +: SB_DATA_W];
    endfunction

    // xor of header bits 0..11
    function automatic logic sb_ctrl_parity(input logic [SB_PACKET_W-1:0] pkt);
        return ^pkt[SB_DATA_LSB-1:0];
    endfunction

endpackage

/* src/sb_packet_builder.sv */
`timescale 1ns/1ns
module sb_packet_builder (
    input  logic                             i_pll_sb_clk,
    input  logic                             i_rst_n,
    // message from the link state machine
    input  logic                             i_tx_msg_valid,
    input  logic [sb_pkg::SB_MSG_NO_W-1:0]   i_tx_msg_no,
    input  logic [sb_pkg::SB_MSG_INFO_W-1:0] i_tx_msg_info,
    input  logic                             i_tx_data_valid,  // selects data opcode
    input  logic [sb_pkg::SB_DATA_W-1:0]     i_tx_data_bus,
    output logic                             o_busy,
    // to serializer
    input  logic                             i_pkt_take,       // frees holding reg
    output logic                             o_pkt_valid,
    output logic [sb_pkg::SB_PACKET_W-1:0]   o_pkt_data
);
    import sb_pkg::*;

    logic                   full;      // holding reg occupied
    logic                   accept;    // message taken this edge
    sb_opcode_e             opcode;
    logic [SB_PACKET_W-1:0] pkt_next;  // packet formed from inputs

    ////////////////////
    // handshake
    ////////////////////
    assign o_busy      = full & ~i_pkt_take;  // a take this cycle makes room
    assign accept      = i_tx_msg_valid & ~o_busy;
    assign o_pkt_valid = full;

    assign opcode = i_tx_data_valid ? SB_OP_MSG_DATA16 : SB_OP_MSG_NODATA;

    ////////////////////
    // packet format
    ////////////////////
    always_comb begin
        pkt_next = '0;  // reserved bits 30..63
        pkt_next[SB_OPCODE_LSB +: SB_OPCODE_W]     = opcode;
        pkt_next[SB_MSG_NO_LSB +: SB_MSG_NO_W]     = i_tx_msg_no;
        pkt_next[SB_MSG_INFO_LSB +: SB_MSG_INFO_W] = i_tx_msg_info;
        if (i_tx_data_valid) begin
            pkt_next[SB_DATA_LSB +: SB_DATA_W] = i_tx_data_bus;  // else left at zero
        end
        // parity over the fields written above
        pkt_next[SB_DP_BIT] = sb_data_parity(pkt_next);
        pkt_next[SB_CP_BIT] = sb_ctrl_parity(pkt_next);
    end

    always_ff @(posedge i_pll_sb_clk) begin
        if (!i_rst_n) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;  // new packet, even if the old one leaves now
        end else if (i_pkt_take) begin
            full <= 1'b0;
        end
    end

    // holding register
    always_ff @(posedge i_pll_sb_clk) begin
        if (accept) begin
            o_pkt_data <= pkt_next;
        end
    end

    // a refused message stays on offer, unchanged, until it is accepted
    a_tx_hold: assert property (@(posedge i_pll_sb_clk) disable iff (!i_rst_n)
        (i_tx_msg_valid && o_busy) |=> (i_tx_msg_valid &&
            $stable({i_tx_msg_no, i_tx_msg_info, i_tx_data_valid, i_tx_data_bus})));

endmodule

/* src/sb_serializer.sv */
`timescale 1ns/1ns
module sb_serializer (
    input  logic                           i_pll_sb_clk,
    input  logic                           i_rst_n,
    // from packet builder
    input  logic                           i_pkt_valid,
    input  logic [sb_pkg::SB_PACKET_W-1:0] i_pkt_data,
    output logic                           o_pkt_take,  // one-cycle load pulse
    // to the sideband serializer
    output logic                           o_sb_ser_data,
    output logic                           o_sb_ser_en,
    output logic                           o_sb_packet_finished
);
    import sb_pkg::*;

    sb_ser_state_e          state;
    logic [SB_PACKET_W-1:0] shift_q;  // lsb goes out first
    logic [SB_CNT_W-1:0]    bit_cnt;  // index of the bit on the line
    logic                   last_bit;

    assign last_bit = (state == SER_SHIFT) && (bit_cnt == SB_CNT_W'(SB_PACKET_W - 1));

    // load when idle, or on the last bit to stream without a gap
    assign o_pkt_take = i_pkt_valid && ((state == SER_IDLE) || last_bit);

    assign o_sb_ser_en          = (state == SER_SHIFT);
    assign o_sb_ser_data        = shift_q[0] & o_sb_ser_en;  // line low when idle
    assign o_sb_packet_finished = last_bit;

    ////////////////////
    // fsm
    ////////////////////
    always_ff @(posedge i_pll_sb_clk) begin
        if (!i_rst_n) begin
            state   <= SER_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                SER_IDLE: begin
                    bit_cnt <= '0;
                    if (i_pkt_valid) begin
                        state <= SER_SHIFT;
                    end
                end
                SER_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;  // wraps to 0 after bit 63
                    if (last_bit && !i_pkt_valid) begin
                        state <= SER_IDLE;  // nothing held
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    // shift register
    always_ff @(posedge i_pll_sb_clk) begin
        if (o_pkt_take) begin
            shift_q <= i_pkt_data;
        end else if (o_sb_ser_en) begin
            shift_q <= shift_q >> 1;
        end
    end

    // an offered packet stays put until it is loaded
    a_pkt_hold: assert property (@(posedge i_pll_sb_clk) disable iff (!i_rst_n)
        (i_pkt_valid && !o_pkt_take) |=> (i_pkt_valid && $stable(i_pkt_data)));

endmodule

/* src/sb_deserializer.sv */
`timescale 1ns/1ns
module sb_deserializer (
    input  logic                           i_pll_sb_clk,
    input  logic                           i_rst_n,
    // from the sideband deserializer
    input  logic                           i_sb_deser_data,
    input  logic                           i_sb_deser_en,   // one bit per enabled cycle
    // to packet decoder
    output logic                           o_rx_pkt_valid,  // one-cycle pulse
    output logic [sb_pkg::SB_PACKET_W-1:0] o_rx_pkt_data
);
    import sb_pkg::*;

    logic [SB_PACKET_W-1:0] shift_q;
    logic [SB_PACKET_W-1:0] shift_next;  // shift_q with the incoming bit on top
    logic [SB_CNT_W-1:0]    bit_cnt;
    logic                   wrap;        // 64th bit being sampled

    // new bit enters at msb, first bit ends up at bit 0
    assign shift_next = {i_sb_deser_data, shift_q[SB_PACKET_W-1:1]};
    assign wrap       = i_sb_deser_en && (bit_cnt == SB_CNT_W'(SB_PACKET_W - 1));

    ////////////////////
    // bit counter
    ////////////////////
    always_ff @(posedge i_pll_sb_clk) begin
        if (!i_rst_n) begin
            bit_cnt        <= '0;
            o_rx_pkt_valid <= 1'b0;
        end else begin
            o_rx_pkt_valid <= wrap;
            if (i_sb_deser_en) begin
                bit_cnt <= bit_cnt + 1'b1;  // rolls over at 64
            end
        end
    end

    always_ff @(posedge i_pll_sb_clk) begin
        if (i_sb_deser_en) begin
            shift_q <= shift_next;
        end
        if (wrap) begin
            o_rx_pkt_data <= shift_next;  // full packet
        end
    end

endmodule

/* src/sb_packet_decoder.sv */
`timescale 1ns/1ns
module sb_packet_decoder (
    input  logic                             i_pll_sb_clk,
    input  logic                             i_rst_n,
    // from deserializer
    input  logic                             i_rx_pkt_valid,
    input  logic [sb_pkg::SB_PACKET_W-1:0]   i_rx_pkt_data,
    // decoded message
    output logic                             o_rx_msg_valid,  // one-cycle pulse
    output logic [sb_pkg::SB_MSG_NO_W-1:0]   o_rx_msg_no,
    output logic [sb_pkg::SB_MSG_INFO_W-1:0] o_rx_msg_info,
    output logic [sb_pkg::SB_DATA_W-1:0]     o_rx_data_bus,
    output logic                             o_rx_data_valid,
    output logic                             o_parity_error
);
    import sb_pkg::*;

    sb_opcode_e opcode;
    logic       op_data16;
    logic       op_known;
    logic       dp_bad;    // data parity mismatch
    logic       cp_bad;    // control parity mismatch
    logic       rsvd_bad;  // reserved bits set
    logic       pkt_err;

    assign opcode    = sb_opcode_e'(i_rx_pkt_data[SB_OPCODE_LSB +: SB_OPCODE_W]);
    assign op_data16 = (opcode == SB_OP_MSG_DATA16);
    assign op_known  = op_data16 || (opcode == SB_OP_MSG_NODATA);

    ////////////////////
    // error checks
    ////////////////////
    assign dp_bad   = i_rx_pkt_data[SB_DP_BIT] != sb_data_parity(i_rx_pkt_data);
    assign cp_bad   = i_rx_pkt_data[SB_CP_BIT] != sb_ctrl_parity(i_rx_pkt_data);
    assign rsvd_bad = |i_rx_pkt_data[SB_PACKET_W-1:SB_CP_BIT+1];
    assign pkt_err  = dp_bad | cp_bad | rsvd_bad | ~op_known;

    always_ff @(posedge i_pll_sb_clk) begin
        if (!i_rst_n) begin
            o_rx_msg_valid <= 1'b0;
            o_parity_error <= 1'b0;
        end else begin
            o_rx_msg_valid <= i_rx_pkt_valid;
            o_parity_error <= i_rx_pkt_valid & pkt_err;  // flagged with its message only
        end
    end

    // message fields
    always_ff @(posedge i_pll_sb_clk) begin
        if (i_rx_pkt_valid) begin
            o_rx_msg_no     <= i_rx_pkt_data[SB_MSG_NO_LSB +: SB_MSG_NO_W];
            o_rx_msg_info   <= i_rx_pkt_data[SB_MSG_INFO_LSB +: SB_MSG_INFO_W];
            o_rx_data_valid <= op_data16;
            o_rx_data_bus   <= op_data16 ? i_rx_pkt_data[SB_DATA_LSB +: SB_DATA_W] : '0;
        end
    end

    // each received packet is flagged once, so it decodes to one message
    a_pkt_pulse: assert property (@(posedge i_pll_sb_clk) disable iff (!i_rst_n)
        i_rx_pkt_valid |=> !i_rx_pkt_valid);

endmodule

/* src/sb_phy_link.sv */
`timescale 1ns/1ns
module sb_phy_link (
    input  logic                             i_pll_sb_clk,  // sideband pll clock
    input  logic                             i_rst_n,
    // transmit message
    input  logic                             i_tx_msg_valid,
    input  logic [sb_pkg::SB_MSG_NO_W-1:0]   i_tx_msg_no,
    input  logic [sb_pkg::SB_MSG_INFO_W-1:0] i_tx_msg_info,
    input  logic                             i_tx_data_valid,
    input  logic [sb_pkg::SB_DATA_W-1:0]     i_tx_data_bus,
    output logic                             o_busy,
    // serial out
    output logic                             o_sb_ser_data,
    output logic                             o_sb_ser_en,
    output logic                             o_sb_packet_finished,
    // serial in
    input  logic                             i_sb_deser_data,
    input  logic                             i_sb_deser_en,
    // received message
    output logic                             o_rx_msg_valid,
    output logic [sb_pkg::SB_MSG_NO_W-1:0]   o_rx_msg_no,
    output logic [sb_pkg::SB_MSG_INFO_W-1:0] o_rx_msg_info,
    output logic [sb_pkg::SB_DATA_W-1:0]     o_rx_data_bus,
    output logic                             o_rx_data_valid,
    output logic                             o_parity_error
);
    import sb_pkg::*;

    ////////////////////
    // internal signals
    ////////////////////
    logic                   pkt_valid;     // builder holds a packet
    logic                   pkt_take;
    logic [SB_PACKET_W-1:0] pkt_data;
    logic                   rx_pkt_valid;
    logic [SB_PACKET_W-1:0] rx_pkt_data;

    ////////////////////
    // transmit path
    ////////////////////
    sb_packet_builder sb_packet_builder_i (
        .i_pll_sb_clk    (i_pll_sb_clk),
        .i_rst_n         (i_rst_n),
        .i_tx_msg_valid  (i_tx_msg_valid),
        .i_tx_msg_no     (i_tx_msg_no),
        .i_tx_msg_info   (i_tx_msg_info),
        .i_tx_data_valid (i_tx_data_valid),
        .i_tx_data_bus   (i_tx_data_bus),
        .o_busy          (o_busy),
        .i_pkt_take      (pkt_take),
        .o_pkt_valid     (pkt_valid),
        .o_pkt_data      (pkt_data)
    );

    sb_serializer sb_serializer_i (
        .i_pll_sb_clk         (i_pll_sb_clk),
        .i_rst_n              (i_rst_n),
        .i_pkt_valid          (pkt_valid),
        .i_pkt_data           (pkt_data),
        .o_pkt_take           (pkt_take),
        .o_sb_ser_data        (o_sb_ser_data),
        .o_sb_ser_en          (o_sb_ser_en),
        .o_sb_packet_finished (o_sb_packet_finished)
    );

    ////////////////////
    // receive path
    ////////////////////
    sb_deserializer sb_deserializer_i (
        .i_pll_sb_clk    (i_pll_sb_clk),
        .i_rst_n         (i_rst_n),
        .i_sb_deser_data (i_sb_deser_data),
        .i_sb_deser_en   (i_sb_deser_en),
        .o_rx_pkt_valid  (rx_pkt_valid),
        .o_rx_pkt_data   (rx_pkt_data)
    );

    sb_packet_decoder sb_packet_decoder_i (
        .i_pll_sb_clk    (i_pll_sb_clk),
        .i_rst_n         (i_rst_n),
        .i_rx_pkt_valid  (rx_pkt_valid),
        .i_rx_pkt_data   (rx_pkt_data),
        .o_rx_msg_valid  (o_rx_msg_valid),
        .o_rx_msg_no     (o_rx_msg_no),
        .o_rx_msg_info   (o_rx_msg_info),
        .o_rx_data_bus   (o_rx_data_bus),
        .o_rx_data_valid (o_rx_data_valid),
        .o_parity_error  (o_parity_error)
    );

endmodule

/* bench/sb_phy_link_tb.sv */
`timescale 1ns/1ns
module sb_phy_link_tb;
    import sb_pkg::*;

    localparam int WAIT_LIMIT = 4000;  // cycles allowed per wait

    logic                     i_pll_sb_clk = 1'b0;
    logic                     i_rst_n;
    logic                     i_tx_msg_valid;
    logic [SB_MSG_NO_W-1:0]   i_tx_msg_no;
    logic [SB_MSG_INFO_W-1:0] i_tx_msg_info;
    logic                     i_tx_data_valid;
    logic [SB_DATA_W-1:0]     i_tx_data_bus;
    logic                     o_busy;
    logic                     o_sb_ser_data;
    logic                     o_sb_ser_en;
    logic                     o_sb_packet_finished;
    logic                     i_sb_deser_data;
    logic                     i_sb_deser_en;
    logic                     o_rx_msg_valid;
    logic [SB_MSG_NO_W-1:0]   o_rx_msg_no;
    logic [SB_MSG_INFO_W-1:0] o_rx_msg_info;
    logic [SB_DATA_W-1:0]     o_rx_data_bus;
    logic                     o_rx_data_valid;
    logic                     o_parity_error;

    integer      seed = 32'h6ec2;
    logic [24:0] exp_q[$];           // {err, dv, no, info, data}
    logic [24:0] rx_exp;
    logic [5:0]  ser_idx;            // index of the bit now on the line
    logic        corrupt_on = 1'b0;
    logic [5:0]  corrupt_pos = '0;
    int          n_accepted = 0;
    int          n_started = 0;
    logic        prev_en = 1'b0;
    logic        gap_check = 1'b0;   // held packet must follow without a gap
    logic        saw_busy = 1'b0;

    sb_phy_link sb_phy_link_i (.*);

    initial begin
        forever #20 i_pll_sb_clk = ~i_pll_sb_clk;
    end

    ////////////////////
    // loopback
    ////////////////////
    assign i_sb_deser_en   = o_sb_ser_en;
    assign i_sb_deser_data = o_sb_ser_data ^ (corrupt_on && ser_idx == corrupt_pos);

    always @(posedge i_pll_sb_clk) begin
        if (!i_rst_n) begin
            ser_idx <= '0;
        end else if (o_sb_ser_en) begin
            ser_idx <= ser_idx + 1'b1;  // wraps with each packet
        end
    end

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // offer one random message, hold it while busy, return on the edge after acceptance
    task automatic send_msg(input logic dv, input logic err);
        logic [SB_MSG_NO_W-1:0]   no;
        logic [SB_MSG_INFO_W-1:0] info;
        logic [SB_DATA_W-1:0]     data;
        int                       waited;
        no              = $random(seed);
        info            = $random(seed);
        data            = $random(seed);  // sent even without data, must be dropped
        waited          = 0;
        i_tx_msg_valid  = 1'b1;
        i_tx_msg_no     = no;
        i_tx_msg_info   = info;
        i_tx_data_valid = dv;
        i_tx_data_bus   = data;
        while (o_busy) begin
            saw_busy = 1'b1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: message was never accepted");
                stop_run();
            end
            @(negedge i_pll_sb_clk);
        end
        exp_q.push_back({err, dv, no, info, dv ? data : 16'h0});
        n_accepted <= n_accepted + 1;  // monitor sees it from the next edge on
        @(negedge i_pll_sb_clk);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %0d messages never came back", exp_q.size());
                stop_run();
            end
            @(negedge i_pll_sb_clk);
        end
    endtask

    ////////////////////
    // monitor
    ////////////////////
    always @(negedge i_pll_sb_clk) begin
        if (i_rst_n) begin
            if (o_sb_ser_en && ser_idx == 6'd0)
                n_started++;
            // finished marks bit 63 and nothing else
            check("o_sb_packet_finished", o_sb_packet_finished, o_sb_ser_en && ser_idx == 6'd63);
            if (prev_en && !o_sb_ser_en && ser_idx != 6'd0) begin
                $display("serial enable dropped after %0d bits of a packet", ser_idx);
                stop_run();
            end
            if (gap_check && !o_sb_ser_en) begin
                $display("idle cycle on the serial line while a packet was held");
                stop_run();
            end
            gap_check = o_sb_packet_finished && (n_accepted > n_started);
            prev_en   = o_sb_ser_en;
            if (o_rx_msg_valid) begin
                if (exp_q.size() == 0) begin
                    $display("received a message that was never sent");
                    stop_run();
                end
                rx_exp = exp_q.pop_front();
                check("o_parity_error", o_parity_error, rx_exp[24]);
                if (!rx_exp[24]) begin  // corrupted fields are not compared
                    check("o_rx_data_valid", o_rx_data_valid, rx_exp[23]);
                    check("o_rx_msg_no", o_rx_msg_no, rx_exp[22:19]);
                    check("o_rx_msg_info", o_rx_msg_info, rx_exp[18:16]);
                    check("o_rx_data_bus", o_rx_data_bus, rx_exp[15:0]);
                end
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////
    initial begin
        i_rst_n         = 1'b0;
        i_tx_msg_valid  = 1'b0;
        i_tx_msg_no     = '0;
        i_tx_msg_info   = '0;
        i_tx_data_valid = 1'b0;
        i_tx_data_bus   = '0;
        repeat (5) @(negedge i_pll_sb_clk);
        i_rst_n = 1'b1;
        @(negedge i_pll_sb_clk);
        check("o_busy", o_busy, 1'b0);
        check("o_sb_ser_en", o_sb_ser_en, 1'b0);
        check("o_sb_packet_finished", o_sb_packet_finished, 1'b0);
        check("o_rx_msg_valid", o_rx_msg_valid, 1'b0);
        check("o_parity_error", o_parity_error, 1'b0);
        // round trip, random gaps so some messages queue up
        for (int i = 0; i < 40; i++) begin
            send_msg($random(seed), 1'b0);
            i_tx_msg_valid = 1'b0;
            repeat ($unsigned($random(seed)) % 80) @(negedge i_pll_sb_clk);
        end
        wait_drained();
        // offered every cycle
        saw_busy = 1'b0;
        for (int i = 0; i < 12; i++)
            send_msg($random(seed), 1'b0);
        i_tx_msg_valid = 1'b0;
        if (!saw_busy) begin
            $display("o_busy never rose during back-to-back messages");
            stop_run();
        end
        wait_drained();
        // one flipped bit in header or data, then a clean message
        for (int i = 0; i < 4; i++) begin
            corrupt_pos = $unsigned($random(seed)) % 28;
            corrupt_on  = 1'b1;
            send_msg($random(seed), 1'b1);
            i_tx_msg_valid = 1'b0;
            wait_drained();
            corrupt_on = 1'b0;
            send_msg($random(seed), 1'b0);
            i_tx_msg_valid = 1'b0;
            wait_drained();
        end
        // every accepted message framed exactly once on the line
        check("packets started", n_started, n_accepted);
        $display("Regression passed");
        $finish;
    end

endmodule

/* project.f */
src/sb_pkg.sv
src/sb_packet_builder.sv
src/sb_serializer.sv
src/sb_deserializer.sv
src/sb_packet_decoder.sv
src/sb_phy_link.sv
bench/sb_phy_link_tb.sv
